//--- logic/regfile_pkg.sv
`default_nettype none

package regfile_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;      // {hi, lo}
    typedef logic [6:0]  reg_addr_t;   // unified address space
    typedef logic [4:0]  gpr_idx_t;
    typedef logic [4:0]  cp0_idx_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [5:0]  hw_int_t;
    typedef logic [1:0]  sw_int_t;

    localparam int num_gpr = 32;

    // address map
    localparam reg_addr_t addr_lo = 7'd64;
    localparam reg_addr_t addr_hi = 7'd127;
    localparam int hilo_sel_bit = 6;
    localparam int cp0_sel_bit  = 5;

    // cp0 indices in use
    localparam cp0_idx_t cp0_badvaddr = 5'd8;
    localparam cp0_idx_t cp0_status   = 5'd12;
    localparam cp0_idx_t cp0_cause    = 5'd13;
    localparam cp0_idx_t cp0_epc      = 5'd14;

    // status fields
    localparam int ie_bit  = 0;
    localparam int exl_bit = 1;
    localparam int im_msb  = 15;
    localparam int im_lsb  = 8;

    // cause fields
    localparam int bd_bit       = 31;
    localparam int hw_ip_msb    = 15;
    localparam int hw_ip_lsb    = 10;
    localparam int sw_ip_msb    = 9;
    localparam int sw_ip_lsb    = 8;
    localparam int exc_code_msb = 6;
    localparam int exc_code_lsb = 2;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } wb_write_t;

    typedef struct packed {
        logic   en;
        dword_t data;
    } hl_write_t;

    typedef struct packed {
        logic      valid;
        logic      eret;
        exc_code_t code;
        word_t     epc;
        word_t     badvaddr;
        logic      bd;
    } exc_req_t;

    typedef struct packed {
        word_t status;
        word_t cause;
        word_t epc;
        word_t badvaddr;
    } cp0_view_t;

    typedef struct packed {
        logic     gpr_en;
        gpr_idx_t gpr_idx;
        word_t    gpr_data;
        logic     lo_en;
        logic     hi_en;
        word_t    lo_data;
        word_t    hi_data;
    } bank_we_t;

    typedef struct packed {
        logic     en;
        cp0_idx_t idx;
        word_t    data;
    } cp0_we_t;

endpackage

`default_nettype wire

//--- logic/write_steer.sv
`timescale 1ns/1ps
`default_nettype none

module write_steer (
    input  wire regfile_pkg::wb_write_t wb,
    input  wire regfile_pkg::hl_write_t hl,
    output regfile_pkg::bank_we_t       bank_we,
    output regfile_pkg::cp0_we_t        cp0_we
);

    logic in_hilo;
    logic in_cp0;
    logic in_gpr;
    logic wb_hi;
    logic wb_lo;

    // address space decode, hi/lo bit outranks the cp0 bit
    assign in_hilo = wb.addr[regfile_pkg::hilo_sel_bit];
    assign in_cp0  = !in_hilo && wb.addr[regfile_pkg::cp0_sel_bit];
    assign in_gpr  = !in_hilo && !wb.addr[regfile_pkg::cp0_sel_bit];

    assign wb_hi = wb.en && (wb.addr == regfile_pkg::addr_hi);
    assign wb_lo = wb.en && (wb.addr == regfile_pkg::addr_lo);

    always_comb begin
        bank_we.gpr_idx  = regfile_pkg::gpr_idx_t'(wb.addr[regfile_pkg::cp0_sel_bit-1:0]);
        bank_we.gpr_data = wb.data;
        bank_we.gpr_en   = wb.en && in_gpr && (bank_we.gpr_idx != '0);  // r0 dropped

        if (hl.en) begin  // muldiv result takes both halves
            bank_we.hi_en   = 1'b1;
            bank_we.lo_en   = 1'b1;
            bank_we.hi_data = hl.data[63:32];
            bank_we.lo_data = hl.data[31:0];
        end else begin
            bank_we.hi_en   = wb_hi;
            bank_we.lo_en   = wb_lo;
            bank_we.hi_data = wb.data;
            bank_we.lo_data = wb.data;
        end
    end

    always_comb begin
        cp0_we.en   = wb.en && in_cp0;
        cp0_we.idx  = regfile_pkg::cp0_idx_t'(wb.addr[regfile_pkg::cp0_sel_bit-1:0]);
        cp0_we.data = wb.data;
    end

endmodule

`default_nettype wire

//--- logic/gpr_hilo_bank.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_hilo_bank (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire regfile_pkg::bank_we_t bank_we,
    output regfile_pkg::word_t         gpr_q [regfile_pkg::num_gpr],
    output regfile_pkg::word_t         hi_q,
    output regfile_pkg::word_t         lo_q
);

    regfile_pkg::word_t regs [1:regfile_pkg::num_gpr-1];  // no storage for r0
    regfile_pkg::word_t hi_r;
    regfile_pkg::word_t lo_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < regfile_pkg::num_gpr; i++) begin
                regs[i] <= '0;
            end
        end else if (bank_we.gpr_en) begin
            regs[bank_we.gpr_idx] <= bank_we.gpr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hi_r <= '0;
            lo_r <= '0;
        end else begin
            if (bank_we.hi_en) begin
                hi_r <= bank_we.hi_data;
            end
            if (bank_we.lo_en) begin
                lo_r <= bank_we.lo_data;
            end
        end
    end

    always_comb begin
        gpr_q[0] = '0;
        for (int i = 1; i < regfile_pkg::num_gpr; i++) begin
            gpr_q[i] = regs[i];
        end
    end

    assign hi_q = hi_r;
    assign lo_q = lo_r;

    // steering must have filtered r0 before it gets here
    a_no_r0_write: assert property (
        @(posedge clk) disable iff (rst)
        bank_we.gpr_en |-> (bank_we.gpr_idx != '0)
    );

endmodule

`default_nettype wire

//--- logic/cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire regfile_pkg::cp0_we_t  cp0_we,
    input  wire regfile_pkg::exc_req_t exc,
    input  wire regfile_pkg::hw_int_t  hw_int,
    output regfile_pkg::cp0_view_t     view,
    output logic                       allow_interrupt
);

    regfile_pkg::word_t     status_q;
    regfile_pkg::word_t     epc_q;
    regfile_pkg::word_t     badvaddr_q;
    logic                   bd_q;
    regfile_pkg::hw_int_t   hw_ip_q;
    regfile_pkg::sw_int_t   sw_ip_q;
    regfile_pkg::exc_code_t exc_code_q;

    logic wr_status;
    logic wr_cause;
    logic wr_epc;
    logic [7:0] pending;

    assign wr_status = cp0_we.en && (cp0_we.idx == regfile_pkg::cp0_status);
    assign wr_cause  = cp0_we.en && (cp0_we.idx == regfile_pkg::cp0_cause);
    assign wr_epc    = cp0_we.en && (cp0_we.idx == regfile_pkg::cp0_epc);

    // status, exception/eret override the software write on exl
    always_ff @(posedge clk) begin
        if (rst) begin
            status_q <= '0;
        end else begin
            if (wr_status) begin
                status_q <= cp0_we.data;
            end
            if (exc.valid) begin
                status_q[regfile_pkg::exl_bit] <= 1'b1;
            end else if (exc.eret) begin
                status_q[regfile_pkg::exl_bit] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hw_ip_q <= '0;
            sw_ip_q <= '0;
        end else begin
            hw_ip_q <= hw_int;  // one cycle behind the pins
            if (wr_cause) begin
                sw_ip_q <= cp0_we.data[regfile_pkg::sw_ip_msb:regfile_pkg::sw_ip_lsb];
            end
        end
    end

    // exception entry state
    always_ff @(posedge clk) begin
        if (rst) begin
            epc_q      <= '0;
            badvaddr_q <= '0;
            bd_q       <= 1'b0;
            exc_code_q <= '0;
        end else begin
            if (wr_epc) begin
                epc_q <= cp0_we.data;
            end
            if (exc.valid) begin
                epc_q      <= exc.epc;     // beats mtc0 epc
                badvaddr_q <= exc.badvaddr;
                bd_q       <= exc.bd;
                exc_code_q <= exc.code;
            end
        end
    end

    always_comb begin
        view.status   = status_q;
        view.epc      = epc_q;
        view.badvaddr = badvaddr_q;

        view.cause = '0;
        view.cause[regfile_pkg::bd_bit] = bd_q;
        view.cause[regfile_pkg::hw_ip_msb:regfile_pkg::hw_ip_lsb] = hw_ip_q;
        view.cause[regfile_pkg::sw_ip_msb:regfile_pkg::sw_ip_lsb] = sw_ip_q;
        view.cause[regfile_pkg::exc_code_msb:regfile_pkg::exc_code_lsb] = exc_code_q;
    end

    // hw and sw pending sit right under the status mask
    assign pending = view.cause[regfile_pkg::hw_ip_msb:regfile_pkg::sw_ip_lsb]
                   & status_q[regfile_pkg::im_msb:regfile_pkg::im_lsb];

    assign allow_interrupt = status_q[regfile_pkg::ie_bit]
                          && !status_q[regfile_pkg::exl_bit]
                          && (|pending);

    // the pipeline raises at most one of these per cycle
    a_exc_eret_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(exc.valid && exc.eret)
    );

endmodule

`default_nettype wire

//--- logic/read_ports.sv
`timescale 1ns/1ps
`default_nettype none

module read_ports (
    input  wire regfile_pkg::reg_addr_t rd_addr_1,
    input  wire regfile_pkg::reg_addr_t rd_addr_2,
    input  wire regfile_pkg::wb_write_t wb,
    input  wire regfile_pkg::hl_write_t hl,
    input  wire regfile_pkg::word_t     gpr_q [regfile_pkg::num_gpr],
    input  wire regfile_pkg::word_t     hi_q,
    input  wire regfile_pkg::word_t     lo_q,
    input  wire regfile_pkg::cp0_view_t cp0,
    output regfile_pkg::word_t          rd_data_1,
    output regfile_pkg::word_t          rd_data_2
);

    regfile_pkg::word_t cp0_field;

    // mfc0 index decode for port 2
    always_comb begin
        case (regfile_pkg::cp0_idx_t'(rd_addr_2[regfile_pkg::cp0_sel_bit-1:0]))
            regfile_pkg::cp0_badvaddr: cp0_field = cp0.badvaddr;
            regfile_pkg::cp0_status:   cp0_field = cp0.status;
            regfile_pkg::cp0_cause:    cp0_field = cp0.cause;
            regfile_pkg::cp0_epc:      cp0_field = cp0.epc;
            default:                   cp0_field = '0;
        endcase
    end

    function automatic regfile_pkg::word_t read_one(
        input regfile_pkg::reg_addr_t addr,
        input regfile_pkg::word_t     cp0_val
    );
        logic is_hi;
        regfile_pkg::word_t val;
        is_hi = (addr == regfile_pkg::addr_hi);
        if (wb.en && (wb.addr == addr) && (addr != '0)) begin
            val = wb.data;                    // write-back bypass
        end else if (hl.en && addr[regfile_pkg::hilo_sel_bit]) begin
            val = is_hi ? hl.data[63:32] : hl.data[31:0];
        end else if (addr[regfile_pkg::hilo_sel_bit]) begin
            val = is_hi ? hi_q : lo_q;
        end else if (addr[regfile_pkg::cp0_sel_bit]) begin
            val = cp0_val;                    // zero on port 1
        end else begin
            val = gpr_q[addr[regfile_pkg::cp0_sel_bit-1:0]];  // entry 0 is zero
        end
        return val;
    endfunction

    always_comb begin
        rd_data_1 = read_one(rd_addr_1, '0);
        rd_data_2 = read_one(rd_addr_2, cp0_field);
    end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire regfile_pkg::wb_write_t wb,
    input  wire regfile_pkg::hl_write_t hl,
    input  wire regfile_pkg::reg_addr_t rd_addr_1,
    input  wire regfile_pkg::reg_addr_t rd_addr_2,
    input  wire regfile_pkg::exc_req_t  exc,
    input  wire regfile_pkg::hw_int_t   hw_int,
    output regfile_pkg::word_t          rd_data_1,
    output regfile_pkg::word_t          rd_data_2,
    output regfile_pkg::cp0_view_t      cp0,
    output logic                        allow_interrupt
);

    regfile_pkg::bank_we_t bank_we;
    regfile_pkg::cp0_we_t  cp0_we;
    regfile_pkg::word_t    gpr_q [regfile_pkg::num_gpr];
    regfile_pkg::word_t    hi_q;
    regfile_pkg::word_t    lo_q;

    write_steer u_steer (
        .wb      (wb),
        .hl      (hl),
        .bank_we (bank_we),
        .cp0_we  (cp0_we)
    );

    gpr_hilo_bank u_bank (
        .clk     (clk),
        .rst     (rst),
        .bank_we (bank_we),
        .gpr_q   (gpr_q),
        .hi_q    (hi_q),
        .lo_q    (lo_q)
    );

    cp0_regs u_cp0 (
        .clk             (clk),
        .rst             (rst),
        .cp0_we          (cp0_we),
        .exc             (exc),
        .hw_int          (hw_int),
        .view            (cp0),
        .allow_interrupt (allow_interrupt)
    );

    // read side sees the raw buses for bypass
    read_ports u_read (
        .rd_addr_1 (rd_addr_1),
        .rd_addr_2 (rd_addr_2),
        .wb        (wb),
        .hl        (hl),
        .gpr_q     (gpr_q),
        .hi_q      (hi_q),
        .lo_q      (lo_q),
        .cp0       (cp0),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2)
    );

endmodule

`default_nettype wire

//--- tests/tb_register_file.sv
`timescale 1ns/1ps
`default_nettype none

module tb_register_file;

    localparam int clk_period    = 8;
    localparam int reset_cycles  = 8;
    localparam int num_vec       = 26;
    localparam int words_per_vec = 14;   // columns per line in the vector file
    localparam int margin_cycles = 20;
    localparam int num_words     = num_vec * words_per_vec;

    logic clk = 1'b0;
    logic rst;

    regfile_pkg::wb_write_t wb;
    regfile_pkg::hl_write_t hl;
    regfile_pkg::reg_addr_t rd_addr_1;
    regfile_pkg::reg_addr_t rd_addr_2;
    regfile_pkg::exc_req_t  exc;
    regfile_pkg::hw_int_t   hw_int;

    regfile_pkg::word_t     rd_data_1;
    regfile_pkg::word_t     rd_data_2;
    regfile_pkg::cp0_view_t cp0;
    logic                   allow_interrupt;

    logic [31:0] vec_mem [num_words];
    int          cur_vec;

    register_file uut (
        .clk             (clk),
        .rst             (rst),
        .wb              (wb),
        .hl              (hl),
        .rd_addr_1       (rd_addr_1),
        .rd_addr_2       (rd_addr_2),
        .exc             (exc),
        .hw_int          (hw_int),
        .rd_data_1       (rd_data_1),
        .rd_data_2       (rd_data_2),
        .cp0             (cp0),
        .allow_interrupt (allow_interrupt)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_word(input string name, input regfile_pkg::word_t got,
                              input regfile_pkg::word_t expected);
        if (got !== expected) begin
            $display("ERROR vector %0d %s got %h expected %h", cur_vec, name, got, expected);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("ERROR vector %0d %s got %h expected %h", cur_vec, name, got, expected);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ctrl word: [31] wb en, [30] hl en, [29] exc valid, [28] eret,
    // [24] bd, [20:16] exc code, [13:8] hw_int, [6:0] wb addr
    task automatic apply_vector(input int base);
        logic [31:0]            ctrl;
        logic [31:0]            rds;
        regfile_pkg::wb_write_t wb_v;
        regfile_pkg::hl_write_t hl_v;
        regfile_pkg::exc_req_t  exc_v;
        ctrl = vec_mem[base];
        rds  = vec_mem[base + 1];
        wb_v.en        = ctrl[31];
        wb_v.addr      = regfile_pkg::reg_addr_t'(ctrl[6:0]);
        wb_v.data      = vec_mem[base + 2];
        hl_v.en        = ctrl[30];
        hl_v.data      = {vec_mem[base + 3], vec_mem[base + 4]};  // hi, lo
        exc_v.valid    = ctrl[29];
        exc_v.eret     = ctrl[28];
        exc_v.bd       = ctrl[24];
        exc_v.code     = regfile_pkg::exc_code_t'(ctrl[20:16]);
        exc_v.epc      = vec_mem[base + 5];
        exc_v.badvaddr = vec_mem[base + 6];
        wb        <= wb_v;
        hl        <= hl_v;
        exc       <= exc_v;
        hw_int    <= regfile_pkg::hw_int_t'(ctrl[13:8]);
        rd_addr_1 <= regfile_pkg::reg_addr_t'(rds[14:8]);
        rd_addr_2 <= regfile_pkg::reg_addr_t'(rds[6:0]);
    endtask

    task automatic check_vector(input int base);
        check_word("rd_data_1", rd_data_1, vec_mem[base + 7]);
        check_word("rd_data_2", rd_data_2, vec_mem[base + 8]);
        check_word("cp0.status", cp0.status, vec_mem[base + 9]);
        check_word("cp0.cause", cp0.cause, vec_mem[base + 10]);
        check_word("cp0.epc", cp0.epc, vec_mem[base + 11]);
        check_word("cp0.badvaddr", cp0.badvaddr, vec_mem[base + 12]);
        check_flag("allow_interrupt", allow_interrupt, vec_mem[base + 13][0]);
    endtask

    initial begin
        rst       <= 1'b1;
        wb        <= '0;
        hl        <= '0;
        rd_addr_1 <= '0;
        rd_addr_2 <= '0;
        exc       <= '0;
        hw_int    <= '0;
        cur_vec = 0;

        for (int k = 0; k < num_words; k++) begin
            vec_mem[k] = ~k;  // overwritten by the file
        end
        $readmemh("tests/regfile_vectors.mem", vec_mem);
        if (vec_mem[num_words - 1] == ~(num_words - 1)) begin
            $display("the vector file is missing or holds fewer vectors than expected");
            $display("TB FAILED");
            $fatal(1, "vector file incomplete");
        end

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < num_vec; i++) begin
            cur_vec = i;
            apply_vector(i * words_per_vec);
            #(clk_period - 1);  // just ahead of the next edge
            check_vector(i * words_per_vec);
            @(posedge clk);
        end

        $display("TB PASSED");
        $finish;
    end

    initial begin
        #((reset_cycles + num_vec + margin_cycles) * clk_period);
        $display("simulation timed out before all vectors were checked");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- tests/regfile_vectors.mem
// ctrl rd_addrs wb_data hl_hi hl_lo exc_epc exc_badvaddr
//   exp_rd1 exp_rd2 exp_status exp_cause exp_epc exp_badvaddr exp_allow
00000000 0000 0 0 0 0 0  0 0 0 0 0 0 0
80000005 0505 12345678 0 0 0 0  12345678 12345678 0 0 0 0 0
00000000 0505 0 0 0 0 0  12345678 12345678 0 0 0 0 0
80000000 0000 deadbeef 0 0 0 0  0 0 0 0 0 0 0
00000000 0005 0 0 0 0 0  0 12345678 0 0 0 0 0
80000007 0705 cafef00d 0 0 0 0  cafef00d 12345678 0 0 0 0 0
80000040 4007 11111111 0 0 0 0  11111111 cafef00d 0 0 0 0 0
8000007f 407f 22222222 0 0 0 0  11111111 22222222 0 0 0 0 0
00000000 7f40 0 0 0 0 0  22222222 11111111 0 0 0 0 0
40000000 7f40 0 aaaa0001 bbbb0002 0 0  aaaa0001 bbbb0002 0 0 0 0 0
00000000 407f 0 0 0 0 0  bbbb0002 aaaa0001 0 0 0 0 0
c000007f 4005 55555555 33330003 44440004 0 0  44440004 12345678 0 0 0 0 0
00000000 7f40 0 0 0 0 0  33330003 44440004 0 0 0 0 0
8000002c 0507 00000401 0 0 0 0  12345678 cafef00d 0 0 0 0 0
00000000 2c2c 0 0 0 0 0  0 00000401 00000401 0 0 0 0
8000002e 2c2c 80001000 0 0 0 0  0 00000401 00000401 0 0 0 0
80000028 2e2e 99999999 0 0 0 0  0 80001000 00000401 0 80001000 0 0
00000000 2828 0 0 0 0 0  0 0 00000401 0 80001000 0 0
00000100 0000 0 0 0 0 0  0 0 00000401 0 80001000 0 0
00000100 2d2d 0 0 0 0 0  0 00000400 00000401 00000400 80001000 0 1
a104012e 2d2d 12121212 0 0 bfc00100 00400003  0 00000400 00000401 00000400 80001000 0 1
00000100 2e2e 0 0 0 0 0  0 bfc00100 00000403 80000410 bfc00100 00400003 0
10000100 2828 0 0 0 0 0  0 00400003 00000403 80000410 bfc00100 00400003 0
00000100 2c2d 0 0 0 0 0  0 80000410 00000401 80000410 bfc00100 00400003 1
00000000 2c2c 0 0 0 0 0  0 00000401 00000401 80000410 bfc00100 00400003 1
00000000 057f 0 0 0 0 0  12345678 33330003 00000401 80000010 bfc00100 00400003 0

//--- tb.f
logic/regfile_pkg.sv
logic/write_steer.sv
logic/gpr_hilo_bank.sv
logic/cp0_regs.sv
logic/read_ports.sv
logic/register_file.sv
tests/tb_register_file.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_register_file -f tb.f -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TB PASSED'; then
    exit 0
fi
exit 1
